/* nc_pkg.sv */
// picture limits, count types, block index union and block index helper
package nc_pkg;

	// ----------------------------------------
	// picture limits
	// ----------------------------------------
	localparam int MB_COLS   = 11;
	localparam int MB_ROWS   = 9;
	localparam int MB_POS_W  = 4;
	localparam int MAX_COEFF = 16;

	// ----------------------------------------
	// count types
	// ----------------------------------------
	typedef logic [4:0] coeff_count_t;

	// 16 counts of one macroblock, by flat block index
	typedef coeff_count_t [15:0] mb_count_arr_t;

	// four counts along a macroblock edge, 0 at left or top
	typedef coeff_count_t [3:0] edge_count_arr_t;

	// ----------------------------------------
	// block index, read flat or as 8x8/4x4 pair
	// ----------------------------------------
	typedef struct packed {
		logic [1:0] blk8;
		logic [1:0] blk4;
	} blk_fields_t;

	typedef union packed {
		logic [3:0]  flat;
		blk_fields_t fields;
	} blk_idx_u;

	// flat index of the block at (row, col) inside a macroblock
	function automatic logic [3:0] blk_flat(input logic [1:0] row, input logic [1:0] col);
		blk_idx_u idx;
		idx.fields.blk8 = {row[1], col[1]};
		idx.fields.blk4 = {row[0], col[0]};
		return idx.flat;
	endfunction

endpackage

/* nc_ctx_if.sv */
// neighbour count context interface with store and deriver modports
`timescale 1ns/1ps

interface nc_ctx_if
	import nc_pkg::*;
();

	// counts of the macroblock being decoded
	mb_count_arr_t   cur_counts;

	// right column of the previous macroblock
	edge_count_arr_t left_counts;

	// bottom row of the macroblock above
	edge_count_arr_t top_counts;

	logic [MB_POS_W-1:0] mb_x;
	logic [MB_POS_W-1:0] mb_y;

	modport store (
		output cur_counts,
		output left_counts,
		output top_counts,
		output mb_x,
		output mb_y
	);

	modport deriver (
		input cur_counts,
		input left_counts,
		input top_counts,
		input mb_x,
		input mb_y
	);

endinterface

/* mb_count_store.sv */
// current macroblock count store, left neighbour column and macroblock position
`timescale 1ns/1ps

module mb_count_store
	import nc_pkg::*;
(
	input  logic                clk,
	input  logic                reset_n,
	input  logic                mb_start,
	input  logic [MB_POS_W-1:0] mb_x,
	input  logic [MB_POS_W-1:0] mb_y,
	input  logic                blk_done,
	input  logic [3:0]          blk_idx,
	input  coeff_count_t        total_coeff,
	input  logic                mb_end,
	nc_ctx_if.store             ctx
);

	blk_idx_u            wr_idx;
	mb_count_arr_t       cur_q;
	edge_count_arr_t     left_q;
	logic [MB_POS_W-1:0] mb_x_q;
	logic [MB_POS_W-1:0] mb_y_q;
	logic                last_col;

	assign wr_idx   = blk_idx;
	assign last_col = (mb_x_q == MB_POS_W'(MB_COLS - 1));

	// ----------------------------------------
	// macroblock position
	// ----------------------------------------
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			mb_x_q <= '0;
			mb_y_q <= '0;
		end
		else if (mb_start)
		begin
			mb_x_q <= mb_x;
			mb_y_q <= mb_y;
		end
	end

	// ----------------------------------------
	// current counts
	// ----------------------------------------
	// cleared per macroblock so uncoded blocks read as zero
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			cur_q <= '0;
		else if (mb_start)
			cur_q <= '0;
		else if (blk_done)
			cur_q[wr_idx.flat] <= total_coeff;
	end

	// right column moves to the left column, not across a row wrap
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			left_q <= '0;
		else if (mb_end && !last_col)
		begin
			for (int r = 0; r < 4; r++)
				left_q[r] <= cur_q[blk_flat(2'(r), 2'd3)];
		end
	end

	assign ctx.cur_counts  = cur_q;
	assign ctx.left_counts = left_q;
	assign ctx.mb_x        = mb_x_q;
	assign ctx.mb_y        = mb_y_q;

endmodule

/* top_row_store.sv */
// bottom edge counts of the macroblock row above, one entry per column
`timescale 1ns/1ps

module top_row_store
	import nc_pkg::*;
(
	input  logic    clk,
	input  logic    reset_n,
	input  logic    mb_end,
	nc_ctx_if.store ctx
);

	edge_count_arr_t row_mem [MB_COLS];
	edge_count_arr_t bottom_row;
	logic            col_ok;

	// positions past the picture width hold nothing
	assign col_ok = (ctx.mb_x < MB_POS_W'(MB_COLS));

	// ----------------------------------------
	// bottom row of the current macroblock
	// ----------------------------------------
	always_comb
	begin
		for (int c = 0; c < 4; c++)
			bottom_row[c] = ctx.cur_counts[blk_flat(2'd3, 2'(c))];
	end

	// ----------------------------------------
	// row store
	// ----------------------------------------
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			for (int c = 0; c < MB_COLS; c++)
				row_mem[c] <= '0;
		end
		else if (mb_end && col_ok)
			row_mem[ctx.mb_x] <= bottom_row;
	end

	// entry written by the macroblock above this one
	assign ctx.top_counts = col_ok ? row_mem[ctx.mb_x] : '0;

endmodule

/* nc_deriver.sv */
// neighbour selection, availability and two stage nC pipeline
`timescale 1ns/1ps

module nc_deriver
	import nc_pkg::*;
(
	input  logic         clk,
	input  logic         reset_n,
	input  logic         blk_query,
	input  logic [3:0]   blk_idx,
	nc_ctx_if.deriver    ctx,
	output coeff_count_t nc,
	output logic         nc_valid
);

	blk_idx_u     q_idx;
	logic [1:0]   col;
	logic [1:0]   row;
	coeff_count_t na;
	coeff_count_t nb;
	logic         a_avail;
	logic         b_avail;

	coeff_count_t na_q;
	coeff_count_t nb_q;
	logic         a_avail_q;
	logic         b_avail_q;
	logic         s1_valid;
	logic [5:0]   sum;

	// block position inside the macroblock
	assign q_idx = blk_idx;
	assign col   = {q_idx.fields.blk8[0], q_idx.fields.blk4[0]};
	assign row   = {q_idx.fields.blk8[1], q_idx.fields.blk4[1]};

	// ----------------------------------------
	// left neighbour
	// ----------------------------------------
	always_comb
	begin
		if (col != 2'd0)
		begin
			a_avail = 1'b1;
			na      = ctx.cur_counts[blk_flat(row, col - 2'd1)];
		end
		else
		begin
			// picture left edge
			a_avail = (ctx.mb_x != '0);
			na      = a_avail ? ctx.left_counts[row] : '0;
		end
	end

	// ----------------------------------------
	// top neighbour
	// ----------------------------------------
	always_comb
	begin
		if (row != 2'd0)
		begin
			b_avail = 1'b1;
			nb      = ctx.cur_counts[blk_flat(row - 2'd1, col)];
		end
		else
		begin
			// picture top edge
			b_avail = (ctx.mb_y != '0);
			nb      = b_avail ? ctx.top_counts[col] : '0;
		end
	end

	// stage one, neighbour counts
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			s1_valid <= 1'b0;
		else
			s1_valid <= blk_query;
	end

	always_ff @(posedge clk)
	begin
		if (blk_query)
		begin
			na_q      <= na;
			nb_q      <= nb;
			a_avail_q <= a_avail;
			b_avail_q <= b_avail;
		end
	end

	// stage two, rounded average or plain sum
	assign sum = {1'b0, na_q} + {1'b0, nb_q};

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			nc       <= '0;
			nc_valid <= 1'b0;
		end
		else
		begin
			nc_valid <= s1_valid;
			if (s1_valid)
			begin
				if (a_avail_q && b_avail_q)
					nc <= coeff_count_t'((sum + 6'd1) >> 1);
				else
					nc <= coeff_count_t'(sum);
			end
		end
	end

endmodule

/* nc_predictor.sv */
// nC predictor top level with count stores, context interface and deriver
`timescale 1ns/1ps

module nc_predictor
	import nc_pkg::*;
(
	input  logic                clk,
	input  logic                reset_n,
	input  logic                mb_start,
	input  logic [MB_POS_W-1:0] mb_x,
	input  logic [MB_POS_W-1:0] mb_y,
	input  logic                blk_query,
	input  logic                blk_done,
	input  logic [3:0]          blk_idx,
	input  coeff_count_t        total_coeff,
	input  logic                mb_end,
	output coeff_count_t        nc,
	output logic                nc_valid
);

	nc_ctx_if ctx ();

	// ----------------------------------------
	// count stores
	// ----------------------------------------
	mb_count_store u_mb_count_store (
		.clk         (clk),
		.reset_n     (reset_n),
		.mb_start    (mb_start),
		.mb_x        (mb_x),
		.mb_y        (mb_y),
		.blk_done    (blk_done),
		.blk_idx     (blk_idx),
		.total_coeff (total_coeff),
		.mb_end      (mb_end),
		.ctx         (ctx)
	);

	top_row_store u_top_row_store (
		.clk     (clk),
		.reset_n (reset_n),
		.mb_end  (mb_end),
		.ctx     (ctx)
	);

	// ----------------------------------------
	// nC derivation
	// ----------------------------------------
	nc_deriver u_nc_deriver (
		.clk       (clk),
		.reset_n   (reset_n),
		.blk_query (blk_query),
		.blk_idx   (blk_idx),
		.ctx       (ctx),
		.nc        (nc),
		.nc_valid  (nc_valid)
	);

endmodule

/* nc_predictor_checker.sv */
// concurrent assertions on the nC predictor answer timing and range, with their bind
`timescale 1ns/1ps

module nc_predictor_checker
	import nc_pkg::*;
(
	input logic         clk,
	input logic         reset_n,
	input logic         blk_query,
	input coeff_count_t nc,
	input logic         nc_valid
);

	// ----------------------------------------
	// answer timing
	// ----------------------------------------
	a_query_answered: assert property (
		@(posedge clk) disable iff (!reset_n)
		$past(blk_query, 2) |-> nc_valid
	) else $error("query not answered two cycles later");

	a_no_stray_valid: assert property (
		@(posedge clk) disable iff (!reset_n)
		nc_valid |-> $past(blk_query, 2)
	) else $error("nc_valid without a query two cycles before");

	// ----------------------------------------
	// value range and reset
	// ----------------------------------------
	a_nc_range: assert property (
		@(posedge clk) disable iff (!reset_n)
		int'(nc) <= MAX_COEFF
	) else $error("nc above the largest count");

	a_reset_quiet: assert property (
		@(posedge clk)
		!reset_n |-> !nc_valid
	) else $error("nc_valid high during reset");

endmodule

bind nc_predictor nc_predictor_checker u_nc_predictor_checker (
	.clk       (clk),
	.reset_n   (reset_n),
	.blk_query (blk_query),
	.nc        (nc),
	.nc_valid  (nc_valid)
);

/* nc_predictor_tb.sv */
// testbench for nc_predictor with clock, stimulus, reference model, compare tasks and watchdog
`timescale 1ns/1ps

module nc_predictor_tb
	import nc_pkg::*;
();

	localparam int TEST_ROWS       = 3;
	localparam int TOTAL_MB        = MB_COLS * TEST_ROWS;
	localparam int WATCHDOG_CYCLES = TOTAL_MB * 16 * 8 + 200;

	logic                clk = 1'b0;
	logic                reset_n;
	logic                mb_start;
	logic [MB_POS_W-1:0] mb_x;
	logic [MB_POS_W-1:0] mb_y;
	logic                blk_query;
	logic                blk_done;
	logic [3:0]          blk_idx;
	coeff_count_t        total_coeff;
	logic                mb_end;
	coeff_count_t        nc;
	logic                nc_valid;

	// reference state
	coeff_count_t model_cur [16];
	coeff_count_t model_left [4];
	coeff_count_t model_top [MB_COLS][4];
	int           cur_mb_x;
	int           cur_mb_y;

	coeff_count_t exp_nc_q [$];
	int           due_q [$];
	int           cycle_cnt = 0;
	logic [15:0]  lfsr_state;

	nc_predictor u_nc_predictor (
		.clk         (clk),
		.reset_n     (reset_n),
		.mb_start    (mb_start),
		.mb_x        (mb_x),
		.mb_y        (mb_y),
		.blk_query   (blk_query),
		.blk_done    (blk_done),
		.blk_idx     (blk_idx),
		.total_coeff (total_coeff),
		.mb_end      (mb_end),
		.nc          (nc),
		.nc_valid    (nc_valid)
	);

	always #5 clk = ~clk;

	always @(posedge clk)
		cycle_cnt <= cycle_cnt + 1;

	// ----------------------------------------
	// random bits
	// ----------------------------------------
	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[6:0], lfsr_state[0]};
		end
	endtask

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	function automatic logic [3:0] flat_of(input logic [1:0] row, input logic [1:0] col);
		return {row[1], col[1], row[0], col[0]};
	endfunction

	function automatic coeff_count_t ref_nc(input logic [3:0] idx);
		blk_idx_u   b;
		logic [1:0] col;
		logic [1:0] row;
		int         na;
		int         nb;
		bit         a_ok;
		bit         b_ok;
		b.flat = idx;
		col = {b.fields.blk8[0], b.fields.blk4[0]};
		row = {b.fields.blk8[1], b.fields.blk4[1]};
		if (col != 2'd0)
		begin
			a_ok = 1'b1;
			na   = int'(model_cur[flat_of(row, col - 2'd1)]);
		end
		else
		begin
			a_ok = (cur_mb_x != 0);
			na   = a_ok ? int'(model_left[row]) : 0;
		end
		if (row != 2'd0)
		begin
			b_ok = 1'b1;
			nb   = int'(model_cur[flat_of(row - 2'd1, col)]);
		end
		else
		begin
			b_ok = (cur_mb_y != 0);
			nb   = b_ok ? int'(model_top[cur_mb_x][col]) : 0;
		end
		if (a_ok && b_ok)
			return coeff_count_t'((na + nb + 1) / 2);
		else
			return coeff_count_t'(na + nb);
	endfunction

	// ----------------------------------------
	// compare tasks
	// ----------------------------------------
	task automatic check_nc(input coeff_count_t got, input coeff_count_t exp);
		if (got !== exp)
		begin
			$display("ERR %0t nc is %0d, expected %0d", $time, got, exp);
			$display("Test failed");
			$fatal(1, "nc mismatch");
		end
	endtask

	task automatic check_valid(input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("ERR %0t nc_valid is %b, expected %b", $time, got, exp);
			$display("Test failed");
			$fatal(1, "nc_valid mismatch");
		end
	endtask

	// outputs only move at the rising edge
	always @(negedge clk)
	begin : compare_proc
		logic exp_valid;
		exp_valid = (due_q.size() != 0) && (due_q[0] == cycle_cnt);
		check_valid(nc_valid, exp_valid);
		if (exp_valid)
		begin
			check_nc(nc, exp_nc_q.pop_front());
			void'(due_q.pop_front());
		end
	end

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	task automatic clear_pulses();
		mb_start  = 1'b0;
		blk_query = 1'b0;
		blk_done  = 1'b0;
		mb_end    = 1'b0;
	endtask

	task automatic start_mb(input int x, input int y);
		@(negedge clk);
		clear_pulses();
		mb_start = 1'b1;
		mb_x     = MB_POS_W'(x);
		mb_y     = MB_POS_W'(y);
		cur_mb_x = x;
		cur_mb_y = y;
		for (int i = 0; i < 16; i++)
			model_cur[i] = '0;
	endtask

	task automatic send_query(input logic [3:0] idx);
		@(negedge clk);
		clear_pulses();
		blk_query = 1'b1;
		blk_idx   = idx;
		exp_nc_q.push_back(ref_nc(idx));
		due_q.push_back(cycle_cnt + 2);
	endtask

	task automatic finish_block(input logic [3:0] idx, input coeff_count_t count);
		@(negedge clk);
		clear_pulses();
		blk_done       = 1'b1;
		blk_idx        = idx;
		total_coeff    = count;
		model_cur[idx] = count;
	endtask

	task automatic end_mb();
		@(negedge clk);
		clear_pulses();
		mb_end = 1'b1;
		// left column does not carry across a row wrap
		if (cur_mb_x != MB_COLS - 1)
		begin
			for (int r = 0; r < 4; r++)
				model_left[r] = model_cur[flat_of(2'(r), 2'd3)];
		end
		for (int c = 0; c < 4; c++)
			model_top[cur_mb_x][c] = model_cur[flat_of(2'd3, 2'(c))];
	endtask

	initial
	begin : main_proc
		logic [7:0] pick;
		reset_n     = 1'b0;
		mb_x        = '0;
		mb_y        = '0;
		blk_idx     = '0;
		total_coeff = '0;
		lfsr_state  = 16'd41215;
		cur_mb_x    = 0;
		cur_mb_y    = 0;
		clear_pulses();
		for (int i = 0; i < 4; i++)
			model_left[i] = '0;
		for (int x = 0; x < MB_COLS; x++)
			for (int c = 0; c < 4; c++)
				model_top[x][c] = '0;

		repeat (3) @(negedge clk);
		reset_n = 1'b1;

		for (int y = 0; y < TEST_ROWS; y++)
		begin
			for (int x = 0; x < MB_COLS; x++)
			begin
				start_mb(x, y);
				for (int b = 0; b < 16; b++)
				begin
					send_query(4'(b));
					// second query in the next cycle
					take_bits(1, pick);
					if (pick[0])
					begin
						take_bits(4, pick);
						send_query(pick[3:0]);
					end
					// a quarter of the blocks stay uncoded
					take_bits(2, pick);
					if (pick[1:0] != 2'd0)
					begin
						take_bits(5, pick);
						finish_block(4'(b), coeff_count_t'(pick % 17));
					end
				end
				end_mb();
			end
		end

		@(negedge clk);
		clear_pulses();
		while (due_q.size() != 0)
			@(negedge clk);
		repeat (4) @(negedge clk);
		$display("Test passed");
		$finish;
	end

	initial
	begin : watchdog_proc
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Test failed");
		$fatal(1, "watchdog expired");
	end

endmodule

/* nc_predictor.f */
nc_pkg.sv
nc_ctx_if.sv
mb_count_store.sv
top_row_store.sv
nc_deriver.sv
nc_predictor.sv
nc_predictor_checker.sv
nc_predictor_tb.sv

/* run.sh */
#!/bin/sh
# build the nC predictor simulation with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f nc_predictor.f \
	--top-module nc_predictor_tb \
	-o nc_predictor_sim \
	&& ./obj_dir/nc_predictor_sim \
	|| { echo "simulation did not complete cleanly"; exit 1; }
